// ==== build.f ====
spi_pkg.sv
spi_ctrl.sv
spi_sclk_gen.sv
spi_shifter.sv
spi_master.sv
spi_assertions.sv
tb_spi_master.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the SPI master testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert --top-module tb_spi_master -f build.f \
    -o Vtb_spi_master > "$LOG" 2>&1 \
    && ./obj_dir/Vtb_spi_master >> "$LOG" 2>&1 \
    || echo "build or run returned an error status" >> "$LOG"

if grep -q '\*\* FAIL \*\*' "$LOG" || ! grep -q '\*\* PASS \*\*' "$LOG"; then
    echo "Simulation failed, see $LOG"
    exit 1
fi

echo "Simulation passed"
exit 0

// ==== spi_assertions.sv ====
module spi_assertions #(
    parameter int NUM_SLAVES = 3
) (
    input  logic                   CLK,
    input  logic                   rst_n_i,
    input  spi_pkg::spi_mode_e     mode_i,
    input  logic                   cs_inv_i,
    input  logic [NUM_SLAVES-1:0]  cs_i,
    input  logic                   sclk_i,
    input  logic                   send_ready_i,
    input  logic                   read_ready_i
);

    logic [NUM_SLAVES-1:0] cs_active;
    int                    fail_count = 0;

    // A line is active when it sits at the cs_inv_i level
    assign cs_active = ~(cs_i ^ {NUM_SLAVES{cs_inv_i}});

    one_cs_active: assert property (@(posedge CLK) disable iff (!rst_n_i)
        $countones(cs_active) <= 1)
        else begin
            fail_count++;
            $error("more than one chip select line is active");
        end

    ready_not_both_low: assert property (@(posedge CLK) disable iff (!rst_n_i)
        send_ready_i || read_ready_i)
        else begin
            fail_count++;
            $error("send and read ready are low together");
        end

    sclk_idle_level: assert property (@(posedge CLK) disable iff (!rst_n_i)
        (cs_active == '0) |-> (sclk_i == mode_i[1]))
        else begin
            fail_count++;
            $error("SCLK left CPOL with no slave selected");
        end

endmodule

bind spi_master spi_assertions #(
    .NUM_SLAVES (NUM_SLAVES)
) u_assertions (
    .CLK          (CLK),
    .rst_n_i      (rst_n_i),
    .mode_i       (mode_i),
    .cs_inv_i     (cs_inv_i),
    .cs_i         (cs_o),
    .sclk_i       (sclk_o),
    .send_ready_i (send_ready_o),
    .read_ready_i (read_ready_o)
);

// ==== spi_ctrl.sv ====
module spi_ctrl #(
    parameter int DATA_WIDTH = 8,
    parameter int NUM_SLAVES = 3,
    localparam int SEL_W = (NUM_SLAVES > 1) ? $clog2(NUM_SLAVES) : 1
) (
    input  logic                   CLK,
    input  logic                   rst_n_i,
    input  spi_pkg::spi_mode_e     mode_i,
    input  logic                   write_req_i,
    input  logic                   read_req_i,
    input  logic [SEL_W-1:0]       slave_sel_i,
    input  logic                   cs_inv_i,
    output spi_pkg::spi_mode_e     mode_o,
    output logic                   active_o,
    output logic                   load_o,
    output logic                   capture_o,
    output logic [NUM_SLAVES-1:0]  cs_o,
    output logic                   send_ready_o,
    output logic                   read_ready_o,
    output spi_pkg::spi_state_e    state_o
);
    import spi_pkg::*;

    localparam int CNT_W = $clog2(2 * DATA_WIDTH);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(2 * DATA_WIDTH - 1);

    spi_state_e        state_q;
    logic [CNT_W-1:0]  cnt_q;
    spi_mode_e         mode_q;
    logic [SEL_W-1:0]  slave_q;
    logic              send_ready_q;
    logic              read_ready_q;
    logic              accept_wr;
    logic              accept_rd;

    // Write wins when both requests are up
    assign accept_wr = (state_q == ST_IDLE) && write_req_i;
    assign accept_rd = (state_q == ST_IDLE) && !write_req_i && read_req_i;

    ////////////////////////////////////////
    // FSM and bit-cycle counter
    ////////////////////////////////////////

    always_ff @(posedge CLK or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q      <= ST_IDLE;
            cnt_q        <= '0;
            mode_q       <= MODE_0;
            slave_q      <= '0;
            send_ready_q <= 1'b1;
            read_ready_q <= 1'b1;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    cnt_q <= '0;
                    if (accept_wr || accept_rd) begin
                        mode_q  <= mode_i;
                        slave_q <= slave_sel_i;
                    end
                    if (accept_wr) begin
                        state_q      <= ST_WRITE;
                        send_ready_q <= 1'b0;
                    end else if (accept_rd) begin
                        state_q      <= ST_READ;
                        read_ready_q <= 1'b0;
                    end
                end
                ST_WRITE, ST_READ: begin
                    // Two CLK cycles per bit
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CNT_LAST) begin
                        state_q <= ST_END;
                    end
                end
                ST_END: begin
                    state_q      <= ST_IDLE;
                    send_ready_q <= 1'b1;
                    read_ready_q <= 1'b1;
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    assign active_o  = (state_q == ST_WRITE) || (state_q == ST_READ);
    assign load_o    = accept_wr;
    // Ready still low in ST_END marks the finished transfer as a read
    assign capture_o = (state_q == ST_END) && !read_ready_q;

    ////////////////////////////////////////
    // Chip selects
    ////////////////////////////////////////

    // Active level is cs_inv_i, idle level its opposite
    always_comb begin
        for (int i = 0; i < NUM_SLAVES; i++) begin
            cs_o[i] = ~cs_inv_i;
            if (active_o && (slave_q == SEL_W'(i))) begin
                cs_o[i] = cs_inv_i;
            end
        end
    end

    assign mode_o       = mode_q;
    assign send_ready_o = send_ready_q;
    assign read_ready_o = read_ready_q;
    assign state_o      = state_q;

endmodule

// ==== spi_master.sv ====
module spi_master #(
    parameter int DATA_WIDTH = 8,
    parameter int NUM_SLAVES = 3,
    localparam int SEL_W = (NUM_SLAVES > 1) ? $clog2(NUM_SLAVES) : 1
) (
    input  logic                   CLK,
    input  logic                   rst_n_i,
    input  spi_pkg::spi_mode_e     mode_i,
    input  logic                   write_req_i,
    input  logic                   read_req_i,
    input  logic [DATA_WIDTH-1:0]  tx_data_i,
    input  logic [SEL_W-1:0]       slave_sel_i,
    input  logic                   cs_inv_i,
    input  logic                   miso_i,
    output logic                   mosi_o,
    output logic                   sclk_o,
    output logic [NUM_SLAVES-1:0]  cs_o,
    output logic                   send_ready_o,
    output logic                   read_ready_o,
    output logic [DATA_WIDTH-1:0]  rx_data_o
);
    import spi_pkg::*;

    spi_mode_e   mode_lat;
    spi_state_e  ctrl_state;
    logic        active;
    logic        load;
    logic        capture;
    logic        shift_stb;
    logic        sample_stb;

    ////////////////////////////////////////
    // Transfer control
    ////////////////////////////////////////

    spi_ctrl #(
        .DATA_WIDTH (DATA_WIDTH),
        .NUM_SLAVES (NUM_SLAVES)
    ) u_ctrl (
        .CLK          (CLK),
        .rst_n_i      (rst_n_i),
        .mode_i       (mode_i),
        .write_req_i  (write_req_i),
        .read_req_i   (read_req_i),
        .slave_sel_i  (slave_sel_i),
        .cs_inv_i     (cs_inv_i),
        .mode_o       (mode_lat),
        .active_o     (active),
        .load_o       (load),
        .capture_o    (capture),
        .cs_o         (cs_o),
        .send_ready_o (send_ready_o),
        .read_ready_o (read_ready_o),
        .state_o      (ctrl_state)
    );

    ////////////////////////////////////////
    // SCLK and data path
    ////////////////////////////////////////

    spi_sclk_gen u_sclk_gen (
        .CLK          (CLK),
        .rst_n_i      (rst_n_i),
        .active_i     (active),
        .mode_i       (mode_lat),
        .idle_mode_i  (mode_i),
        .sclk_o       (sclk_o),
        .shift_stb_o  (shift_stb),
        .sample_stb_o (sample_stb)
    );

    spi_shifter #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_shifter (
        .CLK       (CLK),
        .rst_n_i   (rst_n_i),
        .load_i    (load),
        .tx_data_i (tx_data_i),
        .shift_i   (shift_stb),
        .sample_i  (sample_stb),
        .capture_i (capture),
        .miso_i    (miso_i),
        .mosi_o    (mosi_o),
        .rx_data_o (rx_data_o)
    );

endmodule

// ==== spi_pkg.sv ====
package spi_pkg;

    ////////////////////////////////////////
    // SPI mode
    ////////////////////////////////////////

    // Upper bit is CPOL, lower bit is CPHA
    typedef enum logic [1:0] {
        MODE_0 = 2'b00,
        MODE_1 = 2'b01,
        MODE_2 = 2'b10,
        MODE_3 = 2'b11
    } spi_mode_e;

    ////////////////////////////////////////
    // Controller FSM
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        ST_IDLE  = 2'b00,
        ST_WRITE = 2'b01,
        ST_READ  = 2'b10,
        ST_END   = 2'b11
    } spi_state_e;

endpackage

// ==== spi_sclk_gen.sv ====
module spi_sclk_gen (
    input  logic                CLK,
    input  logic                rst_n_i,
    input  logic                active_i,
    input  spi_pkg::spi_mode_e  mode_i,
    input  spi_pkg::spi_mode_e  idle_mode_i,
    output logic                sclk_o,
    output logic                shift_stb_o,
    output logic                sample_stb_o
);

    logic phase_q;
    logic first_q;
    logic lead;
    logic trail;
    logic flush;

    ////////////////////////////////////////
    // SCLK phase
    ////////////////////////////////////////

    // phase_q high means SCLK sits away from CPOL
    always_ff @(posedge CLK or negedge rst_n_i) begin
        if (!rst_n_i) begin
            phase_q <= 1'b0;
            first_q <= 1'b1;
        end else if (active_i) begin
            phase_q <= ~phase_q;
            if (lead) begin
                first_q <= 1'b0;
            end
        end else begin
            phase_q <= 1'b0;
            first_q <= 1'b1;
        end
    end

    assign sclk_o = active_i ? (phase_q ^ mode_i[1]) : idle_mode_i[1];

    ////////////////////////////////////////
    // Edge strobes
    ////////////////////////////////////////

    // Strobe is high in the cycle that ends with the SCLK edge
    assign lead  = active_i && !phase_q;
    assign trail = active_i && phase_q;

    // One cycle after the transfer, pushes the last CPHA 1 bit out of MOSI
    assign flush = !active_i && !first_q;

    always_comb begin
        if (mode_i[0]) begin
            shift_stb_o  = (lead && !first_q) || flush;
            sample_stb_o = trail;
        end else begin
            shift_stb_o  = trail || flush;
            sample_stb_o = lead;
        end
    end

endmodule

// ==== spi_shifter.sv ====
module spi_shifter #(
    parameter int DATA_WIDTH = 8
) (
    input  logic                   CLK,
    input  logic                   rst_n_i,
    input  logic                   load_i,
    input  logic [DATA_WIDTH-1:0]  tx_data_i,
    input  logic                   shift_i,
    input  logic                   sample_i,
    input  logic                   capture_i,
    input  logic                   miso_i,
    output logic                   mosi_o,
    output logic [DATA_WIDTH-1:0]  rx_data_o
);

    logic [DATA_WIDTH-1:0] tx_q;
    logic [DATA_WIDTH-1:0] rx_q;
    logic [DATA_WIDTH-1:0] rx_hold_q;

    ////////////////////////////////////////
    // Transmit side
    ////////////////////////////////////////

    // MSB first, zeros shifted in behind the word
    always_ff @(posedge CLK or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tx_q <= '0;
        end else if (load_i) begin
            tx_q <= tx_data_i;
        end else if (shift_i) begin
            tx_q <= {tx_q[DATA_WIDTH-2:0], 1'b0};
        end
    end

    assign mosi_o = tx_q[DATA_WIDTH-1];

    ////////////////////////////////////////
    // Receive side
    ////////////////////////////////////////

    // MISO enters at the LSB
    always_ff @(posedge CLK) begin
        if (sample_i) begin
            rx_q <= {rx_q[DATA_WIDTH-2:0], miso_i};
        end
    end

    always_ff @(posedge CLK or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_hold_q <= '0;
        end else if (capture_i) begin
            rx_hold_q <= rx_q;
        end
    end

    assign rx_data_o = rx_hold_q;

endmodule

// ==== tb_spi_master.sv ====
module tb_spi_master;
    import spi_pkg::*;

    localparam int DATA_WIDTH    = 8;
    localparam int NUM_SLAVES    = 3;
    localparam int SEL_W         = (NUM_SLAVES > 1) ? $clog2(NUM_SLAVES) : 1;
    localparam int CLK_PERIOD    = 40;
    localparam int XFER_CYCLES   = 2 * DATA_WIDTH;
    // Reset check plus every transfer run below
    localparam int NUM_TESTS     = 21;
    localparam int WATCHDOG_TIME = NUM_TESTS * (XFER_CYCLES + 4) * CLK_PERIOD * 2;

    logic                   CLK;
    logic                   rst_n_i;
    spi_mode_e              mode_i;
    logic                   write_req_i;
    logic                   read_req_i;
    logic [DATA_WIDTH-1:0]  tx_data_i;
    logic [SEL_W-1:0]       slave_sel_i;
    logic                   cs_inv_i;
    logic                   miso_i = 1'b0;
    logic                   mosi_o;
    logic                   sclk_o;
    logic [NUM_SLAVES-1:0]  cs_o;
    logic                   send_ready_o;
    logic                   read_ready_o;
    logic [DATA_WIDTH-1:0]  rx_data_o;

    logic [31:0]            lfsr_q = 32'hb9bfa380;
    logic [DATA_WIDTH-1:0]  slave_word = '0;
    logic [DATA_WIDTH-1:0]  slave_sh = '0;
    int                     bits_left = 0;
    logic                   miso_next = 1'b0;
    logic                   prev_sel = 1'b0;
    logic                   prev_sclk = 1'b0;
    logic                   mosi_bits[$];

    spi_master #(
        .DATA_WIDTH (DATA_WIDTH),
        .NUM_SLAVES (NUM_SLAVES)
    ) UUT (
        .CLK          (CLK),
        .rst_n_i      (rst_n_i),
        .mode_i       (mode_i),
        .write_req_i  (write_req_i),
        .read_req_i   (read_req_i),
        .tx_data_i    (tx_data_i),
        .slave_sel_i  (slave_sel_i),
        .cs_inv_i     (cs_inv_i),
        .miso_i       (miso_i),
        .mosi_o       (mosi_o),
        .sclk_o       (sclk_o),
        .cs_o         (cs_o),
        .send_ready_o (send_ready_o),
        .read_ready_o (read_ready_o),
        .rx_data_o    (rx_data_o)
    );

    initial begin
        CLK = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            CLK = ~CLK;
        end
    end

    initial begin
        #(WATCHDOG_TIME);
        abort_run("timeout: the tests did not finish in the expected time");
    end

    // Bound port assertions end the run on their first failure
    always @(UUT.u_assertions.fail_count) begin
        if (UUT.u_assertions.fail_count != 0) begin
            abort_run("one of the bound port assertions failed");
        end
    end

    ////////////////////////////////////////
    // Slave model and MOSI monitor
    ////////////////////////////////////////

    // Looks 1 unit after the edge, drives MISO 1 unit later
    always begin : slave_model
        logic now_sel;
        logic sclk_edge;
        logic lead_edge;
        @(posedge CLK);
        #1;
        now_sel   = (cs_o != {NUM_SLAVES{~cs_inv_i}});
        sclk_edge = prev_sel && (sclk_o != prev_sclk);
        lead_edge = (sclk_o != mode_i[1]);
        if (now_sel && !prev_sel) begin
            mosi_bits.delete();
            slave_sh  = slave_word;
            bits_left = DATA_WIDTH;
            // CPHA 0 shows the MSB before the first edge
            if (!mode_i[0]) begin
                miso_next = slave_sh[DATA_WIDTH-1];
                slave_sh  = {slave_sh[DATA_WIDTH-2:0], 1'b0};
                bits_left--;
            end
        end else if (sclk_edge) begin
            if (lead_edge == !mode_i[0]) begin
                mosi_bits.push_back(mosi_o);
            end else if (bits_left > 0) begin
                miso_next = slave_sh[DATA_WIDTH-1];
                slave_sh  = {slave_sh[DATA_WIDTH-2:0], 1'b0};
                bits_left--;
            end
        end
        prev_sel  = now_sel;
        prev_sclk = sclk_o;
        #1;
        miso_i = miso_next;
    end

    ////////////////////////////////////////
    // Helpers and checks
    ////////////////////////////////////////

    function automatic logic [DATA_WIDTH-1:0] random_word();
        logic [DATA_WIDTH-1:0] w;
        w = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
            w = {w[DATA_WIDTH-2:0], lfsr_q[0]};
        end
        return w;
    endfunction

    function automatic logic [NUM_SLAVES-1:0] expected_cs(input logic [SEL_W-1:0] sel,
            input logic act, input logic inv);
        logic [NUM_SLAVES-1:0] pat;
        pat = {NUM_SLAVES{~inv}};
        if (act) begin
            pat[sel] = inv;
        end
        return pat;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input string name, input logic [DATA_WIDTH-1:0] got,
            input logic [DATA_WIDTH-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("error: %s = 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_cs(input logic [NUM_SLAVES-1:0] got,
            input logic [NUM_SLAVES-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("error: cs_o = 0x%0h, expected 0x%0h", got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("error: %s = 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_state(input spi_state_e got, input spi_state_e exp);
        if (got !== exp) begin
            abort_run($sformatf("error: ctrl_state = 0x%0h, expected 0x%0h", got, exp));
        end
    endtask

    task automatic begin_write(input spi_mode_e mode, input logic [SEL_W-1:0] slave,
            input logic [DATA_WIDTH-1:0] word);
        mode_i      = mode;
        slave_sel_i = slave;
        tx_data_i   = word;
        write_req_i = 1'b1;
    endtask

    task automatic begin_read(input spi_mode_e mode, input logic [SEL_W-1:0] slave,
            input logic [DATA_WIDTH-1:0] word);
        mode_i      = mode;
        slave_sel_i = slave;
        slave_word  = word;
        read_req_i  = 1'b1;
    endtask

    // Follows one transfer from the accepting edge until its ready level returns
    task automatic run_transfer(input logic is_write, input logic [SEL_W-1:0] slave,
            input logic [DATA_WIDTH-1:0] word, input logic disturb);
        logic [DATA_WIDTH-1:0] exp_sh;
        int k;
        int low_cycles;
        @(posedge CLK);
        #1;
        check_bit("send_ready_o", send_ready_o, !is_write);
        check_bit("read_ready_o", read_ready_o, is_write);
        if (is_write) begin
            check_state(UUT.ctrl_state, ST_WRITE);
        end else begin
            check_state(UUT.ctrl_state, ST_READ);
        end
        k = 0;
        low_cycles = 0;
        while (!(is_write ? send_ready_o : read_ready_o) && k <= 4 * XFER_CYCLES) begin
            low_cycles++;
            check_cs(cs_o, expected_cs(slave, k < XFER_CYCLES, cs_inv_i));
            if (!is_write) begin
                check_bit("mosi_o", mosi_o, 1'b0);
            end
            #1;
            if (k == 0) begin
                if (is_write) begin
                    write_req_i = 1'b0;
                end else begin
                    read_req_i = 1'b0;
                end
            end
            // Stray requests and data while busy
            if (disturb) begin
                write_req_i = (k < XFER_CYCLES - 1) ? k[0] : 1'b0;
                slave_sel_i = SEL_W'(k % NUM_SLAVES);
                tx_data_i   = ~word;
            end
            @(posedge CLK);
            #1;
            k++;
        end
        if (low_cycles != XFER_CYCLES + 1) begin
            abort_run($sformatf("ready level stayed low for %0d cycles instead of %0d",
                low_cycles, XFER_CYCLES + 1));
        end
        check_state(UUT.ctrl_state, ST_IDLE);
        check_cs(cs_o, expected_cs(slave, 1'b0, cs_inv_i));
        if (is_write) begin
            if (mosi_bits.size() != DATA_WIDTH) begin
                abort_run($sformatf("monitor saw %0d MOSI bits instead of %0d",
                    mosi_bits.size(), DATA_WIDTH));
            end
            exp_sh = word;
            for (int i = 0; i < DATA_WIDTH; i++) begin
                check_bit("mosi_o", mosi_bits[i], exp_sh[DATA_WIDTH-1]);
                exp_sh = {exp_sh[DATA_WIDTH-2:0], 1'b0};
            end
        end else begin
            check_data("rx_data_o", rx_data_o, word);
        end
        #1;
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    task automatic values_after_reset();
        @(posedge CLK);
        #1;
        check_bit("send_ready_o", send_ready_o, 1'b1);
        check_bit("read_ready_o", read_ready_o, 1'b1);
        check_cs(cs_o, {NUM_SLAVES{1'b1}});
        check_bit("mosi_o", mosi_o, 1'b0);
        check_bit("sclk_o", sclk_o, mode_i[1]);
        check_data("rx_data_o", rx_data_o, '0);
        check_state(UUT.ctrl_state, ST_IDLE);
        #1;
    endtask

    task automatic write_every_mode();
        logic [DATA_WIDTH-1:0] word;
        for (int m = 0; m < 4; m++) begin
            for (int s = 0; s < NUM_SLAVES; s++) begin
                word = random_word();
                begin_write(spi_mode_e'(m[1:0]), SEL_W'(s), word);
                run_transfer(1'b1, SEL_W'(s), word, 1'b0);
            end
        end
    endtask

    task automatic read_every_mode();
        logic [DATA_WIDTH-1:0] word;
        for (int m = 0; m < 4; m++) begin
            word = random_word();
            begin_read(spi_mode_e'(m[1:0]), SEL_W'(m % NUM_SLAVES), word);
            run_transfer(1'b0, SEL_W'(m % NUM_SLAVES), word, 1'b0);
        end
    endtask

    task automatic inverted_chip_select();
        logic [DATA_WIDTH-1:0] word;
        cs_inv_i = 1'b1;
        @(posedge CLK);
        #1;
        check_cs(cs_o, '0);
        #1;
        word = random_word();
        begin_write(MODE_1, SEL_W'(2), word);
        run_transfer(1'b1, SEL_W'(2), word, 1'b0);
        word = random_word();
        begin_read(MODE_2, SEL_W'(1), word);
        run_transfer(1'b0, SEL_W'(1), word, 1'b0);
        cs_inv_i = 1'b0;
    endtask

    task automatic write_before_read();
        logic [DATA_WIDTH-1:0] w_word;
        logic [DATA_WIDTH-1:0] r_word;
        w_word = random_word();
        r_word = random_word();
        begin_read(MODE_3, SEL_W'(0), r_word);
        begin_write(MODE_3, SEL_W'(2), w_word);
        run_transfer(1'b1, SEL_W'(2), w_word, 1'b1);
        // Read request was held all along
        slave_sel_i = SEL_W'(0);
        run_transfer(1'b0, SEL_W'(0), r_word, 1'b1);
    endtask

    initial begin
        rst_n_i     = 1'b0;
        mode_i      = MODE_0;
        write_req_i = 1'b0;
        read_req_i  = 1'b0;
        tx_data_i   = '0;
        slave_sel_i = '0;
        cs_inv_i    = 1'b0;
        repeat (3) @(posedge CLK);
        #2;
        rst_n_i = 1'b1;
        values_after_reset();
        write_every_mode();
        read_every_mode();
        inverted_chip_select();
        write_before_read();
        $display("** PASS **");
        $finish;
    end

endmodule
